// ==== Bender.yml ====
package:
  name: xbar_axi

sources:
  - include_dirs:
      - design
    files:
      - design/axi_pkg.sv
      - design/xbar_pkg.sv
      - design/xbar_route_fsm.sv
      - design/xbar_read_switch.sv
      - design/xbar_write_switch.sv
      - design/xbar_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/xbar_slave_model.sv
      - test/xbar_tb.sv

// ==== design/axi_pkg.sv ====
`default_nettype none

`include "xbar_consts.svh"

package axi_pkg;

    // byte address, full word bursts only
    typedef logic [`XBAR_ADDR_W-1:0] addr_t;

    // one data beat
    typedef logic [`XBAR_DATA_W-1:0] data_t;

    // transaction id, echoed on r and b
    typedef logic [`XBAR_ID_W-1:0] id_t;

    // beats minus one
    typedef logic [`XBAR_LEN_W-1:0] len_t;

    typedef logic [`XBAR_RESP_W-1:0] resp_t;

    // byte enables for a write beat
    typedef logic [`XBAR_STRB_W-1:0] strb_t;

endpackage

`default_nettype wire

// ==== design/xbar_consts.svh ====
`ifndef XBAR_CONSTS_SVH
`define XBAR_CONSTS_SVH

// bus widths
`define XBAR_ADDR_W 32
`define XBAR_DATA_W 32
`define XBAR_ID_W 4
`define XBAR_LEN_W 8
`define XBAR_RESP_W 2

// one strobe bit per data byte
`define XBAR_STRB_W (`XBAR_DATA_W / 8)

// timer registers, the only slave 1 addresses
`define XBAR_TIMER_LO 32'h0200_0048
`define XBAR_TIMER_HI 32'h0200_004c

// axi response codes
`define XBAR_RESP_OKAY 2'b00

`endif

// ==== design/xbar_pkg.sv ====
`default_nettype none

`include "xbar_consts.svh"

package xbar_pkg;

    import axi_pkg::*;

    // route machine state, also the switch select
    typedef enum logic [1:0] {
        route_idle = 2'd0,
        route_s0   = 2'd1,
        route_s1   = 2'd2
    } route_t;

    // timer registers live on slave 1
    // everything else falls through to slave 0
    function automatic route_t decode_slave(input addr_t addr);
        route_t sel;
        if (addr == `XBAR_TIMER_LO || addr == `XBAR_TIMER_HI) begin
            sel = route_s1;
        end else begin
            sel = route_s0;
        end
        return sel;
    endfunction

endpackage

`default_nettype wire

// ==== design/xbar_read_switch.sv ====
`timescale 1ns/1ps
`default_nettype none

// ar forward and r return, steered by the read route
module xbar_read_switch
    import axi_pkg::*;
    import xbar_pkg::*;
(
    input  wire route_t route,
    // master ar
    input  wire addr_t  m_araddr,
    input  wire id_t    m_arid,
    input  wire len_t   m_arlen,
    input  wire         m_arvalid,
    output logic        m_arready,
    // master r
    output data_t       m_rdata,
    output resp_t       m_rresp,
    output id_t         m_rid,
    output logic        m_rlast,
    output logic        m_rvalid,
    input  wire         m_rready,
    // slave 0 ar
    output addr_t       s0_araddr,
    output id_t         s0_arid,
    output len_t        s0_arlen,
    output logic        s0_arvalid,
    input  wire         s0_arready,
    // slave 0 r
    input  wire data_t  s0_rdata,
    input  wire resp_t  s0_rresp,
    input  wire id_t    s0_rid,
    input  wire         s0_rlast,
    input  wire         s0_rvalid,
    output logic        s0_rready,
    // slave 1 ar
    output addr_t       s1_araddr,
    output id_t         s1_arid,
    output len_t        s1_arlen,
    output logic        s1_arvalid,
    input  wire         s1_arready,
    // slave 1 r
    input  wire data_t  s1_rdata,
    input  wire resp_t  s1_rresp,
    input  wire id_t    s1_rid,
    input  wire         s1_rlast,
    input  wire         s1_rvalid,
    output logic        s1_rready,
    // last r beat accepted by the master
    output logic        done
);

    always_comb begin
        // idle and unselected ports stay at zero
        m_arready  = 1'b0;
        m_rdata    = '0;
        m_rresp    = '0;
        m_rid      = '0;
        m_rlast    = 1'b0;
        m_rvalid   = 1'b0;
        s0_araddr  = '0;
        s0_arid    = '0;
        s0_arlen   = '0;
        s0_arvalid = 1'b0;
        s0_rready  = 1'b0;
        s1_araddr  = '0;
        s1_arid    = '0;
        s1_arlen   = '0;
        s1_arvalid = 1'b0;
        s1_rready  = 1'b0;
        case (route)
            route_s0: begin
                s0_araddr  = m_araddr;
                s0_arid    = m_arid;
                s0_arlen   = m_arlen;
                s0_arvalid = m_arvalid;
                s0_rready  = m_rready;
                m_arready  = s0_arready;
                m_rdata    = s0_rdata;
                m_rresp    = s0_rresp;
                m_rid      = s0_rid;
                m_rlast    = s0_rlast;
                m_rvalid   = s0_rvalid;
            end
            route_s1: begin
                s1_araddr  = m_araddr;
                s1_arid    = m_arid;
                s1_arlen   = m_arlen;
                s1_arvalid = m_arvalid;
                s1_rready  = m_rready;
                m_arready  = s1_arready;
                m_rdata    = s1_rdata;
                m_rresp    = s1_rresp;
                m_rid      = s1_rid;
                m_rlast    = s1_rlast;
                m_rvalid   = s1_rvalid;
            end
            default: begin
            end
        endcase
    end

    // ends the read burst
    assign done = m_rvalid && m_rready && m_rlast;

    // only one slave may ever see a read request
    a_single_ar: assert #0 (!(s0_arvalid && s1_arvalid));

endmodule

`default_nettype wire

// ==== design/xbar_route_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

// one per direction
// locks onto a slave for a whole burst
module xbar_route_fsm
    import axi_pkg::*;
    import xbar_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    // address channel valid and address from the master
    input  wire        req_valid,
    input  wire addr_t req_addr,
    // final response handshake seen by the switch
    input  wire        done,
    output route_t     route
);

    route_t state_q;
    route_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            route_idle: begin
                // pick the slave while the address is still on the bus
                if (req_valid) begin
                    state_d = decode_slave(req_addr);
                end
            end
            route_s0, route_s1: begin
                if (done) begin
                    state_d = route_idle;
                end
            end
            default: begin
                // unused encoding, recover to idle
                state_d = route_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= route_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // select goes straight to the switch
    assign route = state_q;

    // no request, no route on the next cycle
    a_idle_hold: assert property (
        @(posedge clk) disable iff (rst)
        (route == route_idle && !req_valid) |=> (route == route_idle)
    );

    // done comes from the switch, which is dark while idle
    a_no_done_idle: assert property (
        @(posedge clk) disable iff (rst)
        !(done && route == route_idle)
    );

endmodule

`default_nettype wire

// ==== design/xbar_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// one master, two slaves
// reads and writes route on their own
module xbar_top
    import axi_pkg::*;
    import xbar_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    // master read side
    input  wire addr_t  m_araddr,
    input  wire id_t    m_arid,
    input  wire len_t   m_arlen,
    input  wire         m_arvalid,
    output logic        m_arready,
    output data_t       m_rdata,
    output resp_t       m_rresp,
    output id_t         m_rid,
    output logic        m_rlast,
    output logic        m_rvalid,
    input  wire         m_rready,
    // master write side
    input  wire addr_t  m_awaddr,
    input  wire id_t    m_awid,
    input  wire len_t   m_awlen,
    input  wire         m_awvalid,
    output logic        m_awready,
    input  wire data_t  m_wdata,
    input  wire strb_t  m_wstrb,
    input  wire         m_wlast,
    input  wire         m_wvalid,
    output logic        m_wready,
    output resp_t       m_bresp,
    output id_t         m_bid,
    output logic        m_bvalid,
    input  wire         m_bready,
    // slave 0 read side
    output addr_t       s0_araddr,
    output id_t         s0_arid,
    output len_t        s0_arlen,
    output logic        s0_arvalid,
    input  wire         s0_arready,
    input  wire data_t  s0_rdata,
    input  wire resp_t  s0_rresp,
    input  wire id_t    s0_rid,
    input  wire         s0_rlast,
    input  wire         s0_rvalid,
    output logic        s0_rready,
    // slave 0 write side
    output addr_t       s0_awaddr,
    output id_t         s0_awid,
    output len_t        s0_awlen,
    output logic        s0_awvalid,
    input  wire         s0_awready,
    output data_t       s0_wdata,
    output strb_t       s0_wstrb,
    output logic        s0_wlast,
    output logic        s0_wvalid,
    input  wire         s0_wready,
    input  wire resp_t  s0_bresp,
    input  wire id_t    s0_bid,
    input  wire         s0_bvalid,
    output logic        s0_bready,
    // slave 1 read side, timer
    output addr_t       s1_araddr,
    output id_t         s1_arid,
    output len_t        s1_arlen,
    output logic        s1_arvalid,
    input  wire         s1_arready,
    input  wire data_t  s1_rdata,
    input  wire resp_t  s1_rresp,
    input  wire id_t    s1_rid,
    input  wire         s1_rlast,
    input  wire         s1_rvalid,
    output logic        s1_rready,
    // slave 1 write side
    output addr_t       s1_awaddr,
    output id_t         s1_awid,
    output len_t        s1_awlen,
    output logic        s1_awvalid,
    input  wire         s1_awready,
    output data_t       s1_wdata,
    output strb_t       s1_wstrb,
    output logic        s1_wlast,
    output logic        s1_wvalid,
    input  wire         s1_wready,
    input  wire resp_t  s1_bresp,
    input  wire id_t    s1_bid,
    input  wire         s1_bvalid,
    output logic        s1_bready
);

    route_t read_route;
    route_t write_route;
    logic   read_done;
    logic   write_done;

    // read engine
    xbar_route_fsm u_read_fsm (
        .clk       (clk),
        .rst       (rst),
        .req_valid (m_arvalid),
        .req_addr  (m_araddr),
        .done      (read_done),
        .route     (read_route)
    );

    // write engine, decoded on awaddr
    xbar_route_fsm u_write_fsm (
        .clk       (clk),
        .rst       (rst),
        .req_valid (m_awvalid),
        .req_addr  (m_awaddr),
        .done      (write_done),
        .route     (write_route)
    );

    // channel ports share names with the top, matched by name
    xbar_read_switch u_read_switch (
        .route (read_route),
        .done  (read_done),
        .*
    );

    xbar_write_switch u_write_switch (
        .route (write_route),
        .done  (write_done),
        .*
    );

endmodule

`default_nettype wire

// ==== design/xbar_write_switch.sv ====
`timescale 1ns/1ps
`default_nettype none

// aw and w forward, b return, steered by the write route
module xbar_write_switch
    import axi_pkg::*;
    import xbar_pkg::*;
(
    input  wire route_t route,
    // master aw
    input  wire addr_t  m_awaddr,
    input  wire id_t    m_awid,
    input  wire len_t   m_awlen,
    input  wire         m_awvalid,
    output logic        m_awready,
    // master w
    input  wire data_t  m_wdata,
    input  wire strb_t  m_wstrb,
    input  wire         m_wlast,
    input  wire         m_wvalid,
    output logic        m_wready,
    // master b
    output resp_t       m_bresp,
    output id_t         m_bid,
    output logic        m_bvalid,
    input  wire         m_bready,
    // slave 0 aw, w, b
    output addr_t       s0_awaddr,
    output id_t         s0_awid,
    output len_t        s0_awlen,
    output logic        s0_awvalid,
    input  wire         s0_awready,
    output data_t       s0_wdata,
    output strb_t       s0_wstrb,
    output logic        s0_wlast,
    output logic        s0_wvalid,
    input  wire         s0_wready,
    input  wire resp_t  s0_bresp,
    input  wire id_t    s0_bid,
    input  wire         s0_bvalid,
    output logic        s0_bready,
    // slave 1 aw, w, b
    output addr_t       s1_awaddr,
    output id_t         s1_awid,
    output len_t        s1_awlen,
    output logic        s1_awvalid,
    input  wire         s1_awready,
    output data_t       s1_wdata,
    output strb_t       s1_wstrb,
    output logic        s1_wlast,
    output logic        s1_wvalid,
    input  wire         s1_wready,
    input  wire resp_t  s1_bresp,
    input  wire id_t    s1_bid,
    input  wire         s1_bvalid,
    output logic        s1_bready,
    // b handshake at the master
    output logic        done
);

    always_comb begin
        m_awready  = 1'b0;
        m_wready   = 1'b0;
        m_bresp    = '0;
        m_bid      = '0;
        m_bvalid   = 1'b0;
        s0_awaddr  = '0;
        s0_awid    = '0;
        s0_awlen   = '0;
        s0_awvalid = 1'b0;
        s0_wdata   = '0;
        s0_wstrb   = '0;
        s0_wlast   = 1'b0;
        s0_wvalid  = 1'b0;
        s0_bready  = 1'b0;
        s1_awaddr  = '0;
        s1_awid    = '0;
        s1_awlen   = '0;
        s1_awvalid = 1'b0;
        s1_wdata   = '0;
        s1_wstrb   = '0;
        s1_wlast   = 1'b0;
        s1_wvalid  = 1'b0;
        s1_bready  = 1'b0;
        case (route)
            route_s0: begin
                s0_awaddr  = m_awaddr;
                s0_awid    = m_awid;
                s0_awlen   = m_awlen;
                s0_awvalid = m_awvalid;
                s0_wdata   = m_wdata;
                s0_wstrb   = m_wstrb;
                s0_wlast   = m_wlast;
                s0_wvalid  = m_wvalid;
                s0_bready  = m_bready;
                m_awready  = s0_awready;
                m_wready   = s0_wready;
                m_bresp    = s0_bresp;
                m_bid      = s0_bid;
                m_bvalid   = s0_bvalid;
            end
            route_s1: begin
                // timer writes
                s1_awaddr  = m_awaddr;
                s1_awid    = m_awid;
                s1_awlen   = m_awlen;
                s1_awvalid = m_awvalid;
                s1_wdata   = m_wdata;
                s1_wstrb   = m_wstrb;
                s1_wlast   = m_wlast;
                s1_wvalid  = m_wvalid;
                s1_bready  = m_bready;
                m_awready  = s1_awready;
                m_wready   = s1_wready;
                m_bresp    = s1_bresp;
                m_bid      = s1_bid;
                m_bvalid   = s1_bvalid;
            end
            default: begin
            end
        endcase
    end

    assign done = m_bvalid && m_bready;

    // write data never fans out to both slaves
    a_single_w: assert #0 (!(s0_wvalid && s1_wvalid));

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/axi_pkg.sv
design/xbar_pkg.sv
design/xbar_route_fsm.sv
design/xbar_read_switch.sv
design/xbar_write_switch.sv
design/xbar_top.sv
test/xbar_slave_model.sv
test/xbar_tb.sv

// ==== test/xbar_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_consts.svh"

// behavioral axi slave for the crossbar testbench
// read beat i returns (araddr + 4*i) ^ slave_tag
// one read and one write in flight at most
module xbar_slave_model
    import axi_pkg::*;
#(
    parameter logic [31:0] slave_tag = 32'h0
) (
    input  wire         clk,
    input  wire         rst,
    input  wire addr_t  araddr,
    input  wire id_t    arid,
    input  wire len_t   arlen,
    input  wire         arvalid,
    output logic        arready,
    output data_t       rdata,
    output resp_t       rresp,
    output id_t         rid,
    output logic        rlast,
    output logic        rvalid,
    input  wire         rready,
    input  wire addr_t  awaddr,
    input  wire id_t    awid,
    input  wire len_t   awlen,
    input  wire         awvalid,
    output logic        awready,
    input  wire data_t  wdata,
    input  wire strb_t  wstrb,
    input  wire         wlast,
    input  wire         wvalid,
    output logic        wready,
    output resp_t       bresp,
    output id_t         bid,
    output logic        bvalid,
    input  wire         bready
);

    logic [31:0] rand_q;
    logic [1:0]  ar_wait;
    logic [1:0]  aw_wait;
    logic [1:0]  w_wait;
    logic        rd_busy;
    addr_t       rd_addr;
    len_t        rd_len;
    len_t        rd_beat;
    logic        wr_busy;
    id_t         wr_id;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // free running, tag keeps the two slaves apart
    always_ff @(posedge clk) begin
        if (rst) begin
            rand_q <= 32'hc099_64da ^ slave_tag;
        end else begin
            rand_q <= next_rand(rand_q);
        end
    end

    // read side
    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rdata   <= '0;
            rresp   <= '0;
            rid     <= '0;
            rd_busy <= 1'b0;
            rd_addr <= '0;
            rd_len  <= '0;
            rd_beat <= '0;
            ar_wait <= 2'd0;
        end else if (!rd_busy) begin
            if (arvalid && arready) begin
                // address taken, first beat next cycle
                arready <= 1'b0;
                rd_busy <= 1'b1;
                rd_addr <= araddr;
                rd_len  <= arlen;
                rd_beat <= '0;
                rid     <= arid;
                rresp   <= `XBAR_RESP_OKAY;
                rdata   <= araddr ^ slave_tag;
                rlast   <= (arlen == '0);
                rvalid  <= 1'b1;
            end else if (arvalid) begin
                // random hold-off before arready
                if (ar_wait == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end else begin
                ar_wait <= rand_q[17:16];
            end
        end else if (rvalid && rready) begin
            if (rlast) begin
                rvalid  <= 1'b0;
                rlast   <= 1'b0;
                rd_busy <= 1'b0;
            end else begin
                rd_beat <= rd_beat + 8'd1;
                rdata   <= (rd_addr + ((addr_t'(rd_beat) + 32'd1) << 2)) ^ slave_tag;
                rlast   <= (rd_beat + 8'd1 == rd_len);
            end
        end
    end

    // write side, w only after aw
    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= '0;
            bid     <= '0;
            wr_busy <= 1'b0;
            wr_id   <= '0;
            aw_wait <= 2'd0;
            w_wait  <= 2'd0;
        end else if (!wr_busy) begin
            if (awvalid && awready) begin
                awready <= 1'b0;
                wr_busy <= 1'b1;
                wr_id   <= awid;
                w_wait  <= rand_q[21:20];
            end else if (awvalid) begin
                if (aw_wait == 2'd0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 2'd1;
                end
            end else begin
                aw_wait <= rand_q[19:18];
            end
        end else if (bvalid) begin
            if (bready) begin
                bvalid  <= 1'b0;
                wr_busy <= 1'b0;
            end
        end else if (wvalid && wready) begin
            // one beat per ready, gap before the next
            wready <= 1'b0;
            w_wait <= rand_q[21:20];
            if (wlast) begin
                bvalid <= 1'b1;
                bid    <= wr_id;
                bresp  <= `XBAR_RESP_OKAY;
            end
        end else if (wvalid) begin
            if (w_wait == 2'd0) begin
                wready <= 1'b1;
            end else begin
                w_wait <= w_wait - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/xbar_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_consts.svh"

module xbar_tb
    import axi_pkg::*;
    import xbar_pkg::*;
();

    localparam data_t s0_tag = 32'h5a00_0000;
    localparam data_t s1_tag = 32'h00a5_0000;
    localparam int timeout_cycles = 1000;

    logic  clk;
    logic  rst;
    addr_t m_araddr, s0_araddr, s1_araddr, m_awaddr, s0_awaddr, s1_awaddr;
    id_t   m_arid, s0_arid, s1_arid, m_rid, s0_rid, s1_rid;
    id_t   m_awid, s0_awid, s1_awid, m_bid, s0_bid, s1_bid;
    len_t  m_arlen, s0_arlen, s1_arlen, m_awlen, s0_awlen, s1_awlen;
    data_t m_rdata, s0_rdata, s1_rdata, m_wdata, s0_wdata, s1_wdata;
    resp_t m_rresp, s0_rresp, s1_rresp, m_bresp, s0_bresp, s1_bresp;
    strb_t m_wstrb, s0_wstrb, s1_wstrb;
    logic  m_arvalid, m_arready, m_rlast, m_rvalid, m_rready;
    logic  s0_arvalid, s0_arready, s0_rlast, s0_rvalid, s0_rready;
    logic  s1_arvalid, s1_arready, s1_rlast, s1_rvalid, s1_rready;
    logic  m_awvalid, m_awready, m_wlast, m_wvalid, m_wready, m_bvalid, m_bready;
    logic  s0_awvalid, s0_awready, s0_wlast, s0_wvalid, s0_wready, s0_bvalid, s0_bready;
    logic  s1_awvalid, s1_awready, s1_wlast, s1_wvalid, s1_wready, s1_bvalid, s1_bready;

    // expectations for the read and the write in flight
    // slave index is -1 when nothing is in flight
    int    rd_slave;
    addr_t rd_addr;
    id_t   rd_id;
    len_t  rd_len;
    int    rd_beat;
    int    rd_count;
    int    wr_slave;
    addr_t wr_addr;
    id_t   wr_id;
    len_t  wr_len;
    int    wr_beat;
    int    wr_count;
    int    mismatches;
    int    failures;
    logic [31:0] rng;
    logic [31:0] addr_bits;
    int    i;
    addr_t addr;

    xbar_top uut (.*);

    xbar_slave_model #(.slave_tag(s0_tag)) u_slave0 (
        .clk (clk), .rst (rst),
        .araddr (s0_araddr), .arid (s0_arid), .arlen (s0_arlen),
        .arvalid (s0_arvalid), .arready (s0_arready),
        .rdata (s0_rdata), .rresp (s0_rresp), .rid (s0_rid), .rlast (s0_rlast),
        .rvalid (s0_rvalid), .rready (s0_rready),
        .awaddr (s0_awaddr), .awid (s0_awid), .awlen (s0_awlen),
        .awvalid (s0_awvalid), .awready (s0_awready),
        .wdata (s0_wdata), .wstrb (s0_wstrb), .wlast (s0_wlast),
        .wvalid (s0_wvalid), .wready (s0_wready),
        .bresp (s0_bresp), .bid (s0_bid), .bvalid (s0_bvalid), .bready (s0_bready)
    );

    // timer slave
    xbar_slave_model #(.slave_tag(s1_tag)) u_slave1 (
        .clk (clk), .rst (rst),
        .araddr (s1_araddr), .arid (s1_arid), .arlen (s1_arlen),
        .arvalid (s1_arvalid), .arready (s1_arready),
        .rdata (s1_rdata), .rresp (s1_rresp), .rid (s1_rid), .rlast (s1_rlast),
        .rvalid (s1_rvalid), .rready (s1_rready),
        .awaddr (s1_awaddr), .awid (s1_awid), .awlen (s1_awlen),
        .awvalid (s1_awvalid), .awready (s1_awready),
        .wdata (s1_wdata), .wstrb (s1_wstrb), .wlast (s1_wlast),
        .wvalid (s1_wvalid), .wready (s1_wready),
        .bresp (s1_bresp), .bid (s1_bid), .bvalid (s1_bvalid), .bready (s1_bready)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // timer registers on slave 1 and the rest on slave 0
    function automatic int slave_for_addr(input addr_t a);
        if (a == `XBAR_TIMER_LO || a == `XBAR_TIMER_HI) begin
            return 1;
        end
        return 0;
    endfunction

    function automatic data_t expected_rdata(input int slave, input addr_t a, input int beat);
        data_t tag;
        tag = (slave == 1) ? s1_tag : s0_tag;
        return (a + addr_t'(beat * 4)) ^ tag;
    endfunction

    task automatic report_failure(input string msg);
        failures++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input resp_t got, input resp_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_id(input id_t got, input id_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_len(input len_t got, input len_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_strb(input strb_t got, input strb_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // aw and w as seen by one slave against what the master sent
    task automatic check_write_side(input logic aw_hs, input addr_t awaddr, input id_t awid,
                                    input len_t awlen,
                                    input logic w_hs, input data_t wdata, input strb_t wstrb,
                                    input logic wlast);
        if (aw_hs) begin
            check_addr(awaddr, wr_addr, "forwarded awaddr");
            check_id(awid, wr_id, "forwarded awid");
            check_len(awlen, wr_len, "forwarded awlen");
        end
        if (w_hs) begin
            check_data(wdata, m_wdata, "forwarded wdata");
            check_strb(wstrb, m_wstrb, "forwarded wstrb");
            check_flag(wlast, wr_beat == int'(wr_len), "forwarded wlast");
            wr_beat++;
        end
    endtask

    task automatic expect_quiet();
        if ((s0_arvalid | s1_arvalid | s0_awvalid | s1_awvalid | s0_wvalid | s1_wvalid |
             m_arready | m_awready | m_wready | m_rvalid | m_bvalid |
             s0_rready | s1_rready | s0_bready | s1_bready) !== 1'b0) begin
            report_failure("bus not quiet while no request is pending");
        end
    endtask

    // chan selects ar (0), aw (1) or w (2)
    // returns 1 ns after the handshake edge
    task automatic hold_until_ready(input int chan, input string what);
        int   waited;
        logic seen;
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
            case (chan)
                0: seen = m_arready;
                1: seen = m_awready;
                default: seen = m_wready;
            endcase
        end
        if (!seen) begin
            report_failure({"timeout waiting for ", what});
        end
        @(posedge clk);
        #1;
    endtask

    // counters move in the compare process
    task automatic await_response(input int chan, input int start, input string what);
        int waited;
        waited = 0;
        while (((chan == 0) ? rd_count : wr_count) == start && waited < timeout_cycles) begin
            @(posedge clk);
            waited++;
        end
        if (((chan == 0) ? rd_count : wr_count) == start) begin
            report_failure({"timeout waiting for ", what});
        end
        #1;
    endtask

    task automatic read_burst(input addr_t a, input id_t id, input len_t len);
        int start;
        @(posedge clk);
        #1;
        rd_slave = slave_for_addr(a);
        rd_addr = a;
        rd_id = id;
        rd_len = len;
        rd_beat = 0;
        start = rd_count;
        m_araddr = a;
        m_arid = id;
        m_arlen = len;
        m_arvalid = 1'b1;
        m_rready = 1'b1;
        hold_until_ready(0, "read address ready");
        m_arvalid = 1'b0;
        m_araddr = '0;
        m_arid = '0;
        m_arlen = '0;
        await_response(0, start, "last read beat");
        m_rready = 1'b0;
    endtask

    task automatic write_burst(input addr_t a, input id_t id, input len_t len);
        int start;
        int beat;
        @(posedge clk);
        #1;
        wr_slave = slave_for_addr(a);
        wr_addr = a;
        wr_id = id;
        wr_len = len;
        wr_beat = 0;
        start = wr_count;
        m_awaddr = a;
        m_awid = id;
        m_awlen = len;
        m_awvalid = 1'b1;
        m_bready = 1'b1;
        hold_until_ready(1, "write address ready");
        m_awvalid = 1'b0;
        m_awaddr = '0;
        m_awid = '0;
        m_awlen = '0;
        for (beat = 0; beat <= int'(len); beat++) begin
            rng = lcg_next(rng);
            m_wdata = rng;
            m_wstrb = rng[7:4];
            m_wlast = (beat == int'(len));
            m_wvalid = 1'b1;
            hold_until_ready(2, "write data ready");
        end
        m_wvalid = 1'b0;
        m_wdata = '0;
        m_wstrb = '0;
        m_wlast = 1'b0;
        await_response(1, start, "write response");
        m_bready = 1'b0;
    endtask

    // compares at the falling edge where everything has settled
    always @(negedge clk) begin
        if (!rst) begin
            if ((s0_arvalid && rd_slave != 0) || (s1_arvalid && rd_slave != 1)) begin
                report_failure("read address reached a slave it was not decoded to");
            end
            if (((s0_awvalid || s0_wvalid) && wr_slave != 0) ||
                ((s1_awvalid || s1_wvalid) && wr_slave != 1)) begin
                report_failure("write reached a slave it was not decoded to");
            end
            if (m_rvalid && m_rready) begin
                check_data(m_rdata, expected_rdata(rd_slave, rd_addr, rd_beat), "rdata");
                check_id(m_rid, rd_id, "rid");
                check_resp(m_rresp, `XBAR_RESP_OKAY, "rresp");
                check_flag(m_rlast, rd_beat == int'(rd_len), "rlast");
                rd_beat++;
                if (m_rlast) begin
                    rd_slave = -1;
                    rd_count++;
                end
            end
            check_write_side(s0_awvalid && s0_awready, s0_awaddr, s0_awid, s0_awlen,
                             s0_wvalid && s0_wready, s0_wdata, s0_wstrb, s0_wlast);
            check_write_side(s1_awvalid && s1_awready, s1_awaddr, s1_awid, s1_awlen,
                             s1_wvalid && s1_wready, s1_wdata, s1_wstrb, s1_wlast);
            if (m_bvalid && m_bready) begin
                check_id(m_bid, wr_id, "bid");
                check_resp(m_bresp, `XBAR_RESP_OKAY, "bresp");
                wr_slave = -1;
                wr_count++;
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        m_araddr = '0;
        m_arid = '0;
        m_arlen = '0;
        m_arvalid = 1'b0;
        m_rready = 1'b0;
        m_awaddr = '0;
        m_awid = '0;
        m_awlen = '0;
        m_awvalid = 1'b0;
        m_wdata = '0;
        m_wstrb = '0;
        m_wlast = 1'b0;
        m_wvalid = 1'b0;
        m_bready = 1'b0;
        rd_slave = -1;
        wr_slave = -1;
        rd_count = 0;
        wr_count = 0;
        mismatches = 0;
        failures = 0;
        rng = 32'hc099_64da;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle bus stays dark
        repeat (8) begin
            @(negedge clk);
            expect_quiet();
        end

        // ordinary read then both timer registers
        read_burst(32'h0000_1000, 4'h3, 8'd3);
        read_burst(`XBAR_TIMER_LO, 4'h5, 8'd0);
        read_burst(`XBAR_TIMER_HI, 4'h6, 8'd1);

        write_burst(32'h0000_2040, 4'h9, 8'd2);
        write_burst(`XBAR_TIMER_LO, 4'ha, 8'd0);
        write_burst(`XBAR_TIMER_HI, 4'hb, 8'd1);

        // timer read and plain write in the same cycle
        fork
            read_burst(`XBAR_TIMER_HI, 4'hc, 8'd2);
            write_burst(32'h0000_3000, 4'hd, 8'd3);
        join

        // random mix where half the picks land on a timer
        for (i = 0; i < 40; i++) begin
            rng = lcg_next(rng);
            case (rng[30:29])
                2'd0: addr = `XBAR_TIMER_LO;
                2'd1: addr = `XBAR_TIMER_HI;
                default: begin
                    // word aligned ordinary address
                    addr_bits = lcg_next(rng);
                    addr = {4'h0, addr_bits[31:6], 2'b00};
                end
            endcase
            if (rng[31]) begin
                write_burst(addr, rng[26:23], len_t'(rng[28:27]));
            end else begin
                read_burst(addr, rng[26:23], len_t'(rng[28:27]));
            end
        end

        repeat (4) @(posedge clk);
        $display("run complete, %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
